//--- list.f
source/mmio_pkg.sv
source/address_decoder.sv
source/wishbone_manager.sv
source/sram_wb_slave.sv
source/keypad_register.sv
source/ack_center.sv
source/mmio.sv
testbench/mmio_tb.sv

//--- testbench/mmio_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_tb;

    import mmio_pkg::*;

    localparam logic [31:0] RANDOM_SEED = 32'h3951_2c04;
    localparam int          ACK_TIMEOUT = 20;

    logic       clk;
    logic       rst_n;
    cpu_req_t   cpu_req;
    logic [4:0] button;
    logic [1:0] app;
    logic       key_rising;
    logic       display_ack;
    logic       d_ack_o;
    logic       i_ack_o;
    word_t      memload_o;
    word_t      instruction_o;
    word_t      display_addr_o;
    word_t      display_data_o;
    logic       display_wen_o;

    // Scoreboard of SRAM words and the keypad word
    word_t ram_model [SRAM_DEPTH];
    bit    ram_known [SRAM_DEPTH];
    word_t key_model;
    word_t exp_load;
    logic  exp_known;
    int    check_errors;
    int    tests_run;
    int    tests_failed;

    logic req_active;
    logic in_ram;
    logic in_keypad;
    logic in_display;
    logic ram_req;
    int   req_idx;

    mmio mmio_i (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .req_i          (cpu_req),
        .d_ack_o        (d_ack_o),
        .i_ack_o        (i_ack_o),
        .memload_o      (memload_o),
        .instruction_o  (instruction_o),
        .button_i       (button),
        .app_i          (app),
        .key_rising_i   (key_rising),
        .display_addr_o (display_addr_o),
        .display_data_o (display_data_o),
        .display_wen_o  (display_wen_o),
        .display_ack_i  (display_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign req_active = cpu_req.read || cpu_req.write;
    assign in_ram     = (cpu_req.addr >= RAM_BASE) && (cpu_req.addr <= RAM_LIMIT);
    assign in_keypad  = (cpu_req.addr == KEYPAD_ADDR);
    assign in_display = (cpu_req.addr >= DISPLAY_BASE) && (cpu_req.addr <= DISPLAY_LIMIT);
    assign ram_req    = in_ram && req_active;
    assign req_idx    = (cpu_req.addr >> 2) % SRAM_DEPTH;

    // Expected load word by region
    always_comb begin
        exp_known = 1'b1;
        if (in_ram) begin
            exp_load  = ram_model[req_idx];
            exp_known = ram_known[req_idx];
        end else if (in_keypad) begin
            exp_load = key_model;
        end else begin
            exp_load = ERROR_WORD;
        end
    end

    load_value: assert property (@(posedge clk) disable iff (!rst_n)
        (d_ack_o && cpu_req.read && exp_known) |-> (memload_o == exp_load))
        else begin
            $display("CHECK FAILED memload_o: got %h, expected %h",
                     $sampled(memload_o), $sampled(exp_load));
            check_errors++;
        end

    fetch_value: assert property (@(posedge clk) disable iff (!rst_n)
        (d_ack_o && cpu_req.read && exp_known) |-> (instruction_o == exp_load))
        else begin
            $display("CHECK FAILED instruction_o: got %h, expected %h",
                     $sampled(instruction_o), $sampled(exp_load));
            check_errors++;
        end

    // Request first sampled at E0, ack seen only at the edge after E2
    ram_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ram_req) |-> !d_ack_o [*3] ##1 d_ack_o ##1 !d_ack_o)
        else begin
            $display("SRAM access was not acknowledged for exactly one cycle after two edges");
            check_errors++;
        end

    fetch_ack_on_load: assert property (@(posedge clk) disable iff (!rst_n)
        (d_ack_o && cpu_req.read && in_ram) |-> i_ack_o)
        else begin
            $display("CHECK FAILED i_ack_o: got %h, expected %h", $sampled(i_ack_o), 1'b1);
            check_errors++;
        end

    fetch_ack_only_load: assert property (@(posedge clk) disable iff (!rst_n)
        i_ack_o |-> (d_ack_o && cpu_req.read && in_ram))
        else begin
            $display("i_ack_o was raised outside a completed SRAM read");
            check_errors++;
        end

    // Keypad and unmapped accesses finish in the cycle they appear
    instant_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (req_active && !in_ram && !in_display) |-> d_ack_o)
        else begin
            $display("Keypad or unmapped access to %h was not acknowledged at once",
                     $sampled(cpu_req.addr));
            check_errors++;
        end

    display_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_req.write && in_display) |-> display_wen_o)
        else begin
            $display("CHECK FAILED display_wen_o: got %h, expected %h",
                     $sampled(display_wen_o), 1'b1);
            check_errors++;
        end

    display_fields: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_req.write && in_display) |->
            (display_addr_o == cpu_req.addr) && (display_data_o == cpu_req.wdata))
        else begin
            $display("CHECK FAILED display_addr_o/display_data_o: got %h/%h, expected %h/%h",
                     $sampled(display_addr_o), $sampled(display_data_o),
                     $sampled(cpu_req.addr), $sampled(cpu_req.wdata));
            check_errors++;
        end

    display_ack_follow: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_req.write && in_display) |-> (d_ack_o == display_ack))
        else begin
            $display("CHECK FAILED d_ack_o: got %h, expected %h",
                     $sampled(d_ack_o), $sampled(display_ack));
            check_errors++;
        end

    display_strobe_only: assert property (@(posedge clk) disable iff (!rst_n)
        display_wen_o |-> (cpu_req.write && in_display))
        else begin
            $display("display_wen_o was raised without a display write");
            check_errors++;
        end

    // Holds through reset as well
    quiet_when_idle: assert property (@(posedge clk)
        !req_active |-> (!d_ack_o && !i_ack_o && !display_wen_o))
        else begin
            $display("An acknowledge or display strobe was raised with no request present");
            check_errors++;
        end

    task automatic cpu_access(input word_t addr, input word_t wdata, input logic is_write);
        int waited;
        @(posedge clk);
        cpu_req.addr  <= addr;
        cpu_req.wdata <= wdata;
        cpu_req.read  <= !is_write;
        cpu_req.write <= is_write;
        waited = 0;
        @(negedge clk);
        while (!d_ack_o && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!d_ack_o) begin
            $display("Timeout waiting for d_ack_o on the access to %h", addr);
            check_errors++;
        end
        @(posedge clk);
        cpu_req <= '0;
        if (is_write && addr <= RAM_LIMIT) begin
            ram_model[(addr >> 2) % SRAM_DEPTH] = wdata;
            ram_known[(addr >> 2) % SRAM_DEPTH] = 1'b1;
        end
        if (!is_write && addr == KEYPAD_ADDR) begin
            key_model[KEY_VALID_BIT] = 1'b0;
        end
    endtask

    task automatic display_write(input word_t addr, input word_t data);
        int delay;
        int waited;
        delay = 1 + ($urandom % 5);
        @(posedge clk);
        cpu_req.addr  <= addr;
        cpu_req.wdata <= data;
        cpu_req.read  <= 1'b0;
        cpu_req.write <= 1'b1;
        repeat (delay) @(posedge clk);
        display_ack <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!d_ack_o && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!d_ack_o) begin
            $display("Timeout waiting for d_ack_o on the display write to %h", addr);
            check_errors++;
        end
        @(posedge clk);
        cpu_req     <= '0;
        display_ack <= 1'b0;
    endtask

    task automatic pulse_key(input logic [1:0] app_val, input logic [4:0] button_val);
        @(posedge clk);
        app        <= app_val;
        button     <= button_val;
        key_rising <= 1'b1;
        @(posedge clk);
        key_rising <= 1'b0;
        key_model                = '0;
        key_model[KEY_VALID_BIT] = 1'b1;
        key_model[6:5]           = app_val;
        key_model[4:0]           = button_val;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        // Let trailing property checks settle
        repeat (3) @(posedge clk);
        tests_run++;
        if (check_errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, check_errors - errors_before);
        end
    endtask

    initial begin
        word_t addr_q[$];
        word_t addr;
        int    errors_before;
        void'($urandom(RANDOM_SEED));
        rst_n        = 1'b0;
        cpu_req      = '0;
        button       = '0;
        app          = '0;
        key_rising   = 1'b0;
        display_ack  = 1'b0;
        key_model    = '0;
        check_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            ram_model[i] = '0;
            ram_known[i] = 1'b0;
        end

        errors_before = check_errors;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        cpu_access(KEYPAD_ADDR, '0, 1'b0);
        finish_test("reset_state", errors_before);

        errors_before = check_errors;
        for (int i = 0; i < 8; i++) begin
            addr = RAM_BASE + (($urandom % SRAM_DEPTH) << 2);
            addr_q.push_back(addr);
            cpu_access(addr, $urandom, 1'b1);
        end
        // Overwrite two words so that the last store must win
        cpu_access(addr_q[0], $urandom, 1'b1);
        cpu_access(addr_q[1], $urandom, 1'b1);
        foreach (addr_q[i]) begin
            cpu_access(addr_q[i], '0, 1'b0);
        end
        finish_test("sram_write_read", errors_before);

        errors_before = check_errors;
        pulse_key(2'($urandom), 5'($urandom));
        cpu_access(KEYPAD_ADDR, '0, 1'b0);
        cpu_access(KEYPAD_ADDR, '0, 1'b0);
        finish_test("keypad_capture", errors_before);

        errors_before = check_errors;
        for (int i = 0; i < 4; i++) begin
            display_write(DISPLAY_BASE + (($urandom % 64) << 2), $urandom);
        end
        finish_test("display_write", errors_before);

        errors_before = check_errors;
        cpu_access(32'h0000_8000 + (($urandom % 256) << 2), '0, 1'b0);
        // Same word index as a stored SRAM word, but outside the map
        cpu_access(addr_q[0] + 32'h0000_1000, $urandom, 1'b1);
        cpu_access(addr_q[0], '0, 1'b0);
        finish_test("unmapped_access", errors_before);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, check_errors);
        if (tests_failed == 0 && check_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/mmio.sv
`timescale 1ns/1ps
`default_nettype none

module mmio (
    input  logic               clk,
    input  logic               rst_n_i,

    // CPU data port
    input  mmio_pkg::cpu_req_t req_i,
    output logic               d_ack_o,
    output logic               i_ack_o,
    output mmio_pkg::word_t    memload_o,
    output mmio_pkg::word_t    instruction_o,

    // Keypad
    input  logic [4:0]         button_i,
    input  logic [1:0]         app_i,
    input  logic               key_rising_i,

    // Display write port
    output mmio_pkg::word_t    display_addr_o,
    output mmio_pkg::word_t    display_data_o,
    output logic               display_wen_o,
    input  logic               display_ack_i
);

    import mmio_pkg::*;

    region_e region;
    logic    ram_sel;
    logic    ram_done;
    logic    key_read_done;
    word_t   ram_rdata;
    word_t   key_word;
    wb_m2s_t wb_m2s;
    wb_s2m_t wb_s2m;

    address_decoder addr_dec (
        .addr_i        (req_i.addr),
        .write_i       (req_i.write),
        .region_o      (region),
        .display_wen_o (display_wen_o)
    );

    assign ram_sel = (region == REGION_RAM);

    wishbone_manager wb_mgr (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .ram_sel_i (ram_sel),
        .wb_o      (wb_m2s),
        .wb_i      (wb_s2m),
        .rdata_o   (ram_rdata),
        .done_o    (ram_done)
    );

    sram_wb_slave sram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (wb_m2s),
        .wb_o    (wb_s2m)
    );

    // Valid flag drops once the CPU has the keypad word
    assign key_read_done = (region == REGION_KEYPAD) && req_i.read && d_ack_o;

    keypad_register key_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .button_i     (button_i),
        .app_i        (app_i),
        .key_rising_i (key_rising_i),
        .read_done_i  (key_read_done),
        .key_word_o   (key_word)
    );

    ack_center acks (
        .region_i      (region),
        .read_i        (req_i.read),
        .write_i       (req_i.write),
        .ram_done_i    (ram_done),
        .display_ack_i (display_ack_i),
        .d_ack_o       (d_ack_o),
        .i_ack_o       (i_ack_o)
    );

    // Load data by region
    always_comb begin
        case (region)
            REGION_RAM:    memload_o = ram_rdata;
            REGION_KEYPAD: memload_o = key_word;
            default:       memload_o = ERROR_WORD;
        endcase
    end

    assign instruction_o = memload_o;

    // Display port sees the raw request
    assign display_addr_o = req_i.addr;
    assign display_data_o = req_i.wdata;

    // SRAM access acks two edges after the cycle opens, for one cycle
    a_ram_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(wb_m2s.cyc) |-> ##2 (d_ack_o ##1 !d_ack_o));

endmodule

`default_nettype wire

//--- source/ack_center.sv
`timescale 1ns/1ps
`default_nettype none

module ack_center (
    input  mmio_pkg::region_e region_i,
    input  logic              read_i,
    input  logic              write_i,
    input  logic              ram_done_i,
    input  logic              display_ack_i,
    output logic              d_ack_o,
    output logic              i_ack_o
);

    import mmio_pkg::*;

    logic active;

    assign active = read_i || write_i;

    always_comb begin
        case (region_i)
            REGION_RAM: begin
                d_ack_o = active && ram_done_i;
            end
            // Stores wait for the display, loads return the error word at once
            REGION_DISPLAY: begin
                d_ack_o = write_i ? display_ack_i : read_i;
            end
            default: begin
                d_ack_o = active;
            end
        endcase
    end

    // Fetch shares the port, only SRAM loads count as instructions
    assign i_ack_o = (region_i == REGION_RAM) && read_i && ram_done_i;

endmodule

`default_nettype wire

//--- source/keypad_register.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_register (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [4:0]      button_i,
    input  logic [1:0]      app_i,
    input  logic            key_rising_i,
    input  logic            read_done_i,
    output mmio_pkg::word_t key_word_o
);

    import mmio_pkg::*;

    logic       valid_q;
    logic [1:0] app_q;
    logic [4:0] button_q;

    // Newest key event wins over a read in the same cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            app_q    <= '0;
            button_q <= '0;
        end else if (key_rising_i) begin
            valid_q  <= 1'b1;
            app_q    <= app_i;
            button_q <= button_i;
        end else if (read_done_i) begin
            valid_q <= 1'b0;
        end
    end

    // Word layout: valid flag on top, app in 6:5, button in 4:0
    always_comb begin
        key_word_o                = '0;
        key_word_o[KEY_VALID_BIT] = valid_q;
        key_word_o[6:5]           = app_q;
        key_word_o[4:0]           = button_q;
    end

endmodule

`default_nettype wire

//--- source/sram_wb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sram_wb_slave (
    input  logic              clk,
    input  logic              rst_n_i,
    input  mmio_pkg::wb_m2s_t wb_i,
    output mmio_pkg::wb_s2m_t wb_o
);

    import mmio_pkg::*;

    word_t                     mem [SRAM_DEPTH];
    word_t                     dat_q;
    logic                      ack_q;
    logic                      access;
    logic [SRAM_ADDR_BITS-1:0] word_idx;

    // Byte address to word index
    assign word_idx = wb_i.adr[SRAM_ADDR_BITS+BYTE_OFFSET_BITS-1:BYTE_OFFSET_BITS];

    // New access only while no ack is out, so each ack is a single pulse
    assign access = wb_i.cyc && wb_i.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Array port, write and read at the ack edge
    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_i.we) begin
                mem[word_idx] <= wb_i.dat;
            end
            dat_q <= mem[word_idx];
        end
    end

    always_comb begin
        wb_o.dat = dat_q;
        wb_o.ack = ack_q;
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_o.ack |=> !wb_o.ack);

endmodule

`default_nettype wire

//--- source/wishbone_manager.sv
`timescale 1ns/1ps
`default_nettype none

module wishbone_manager (
    input  logic               clk,
    input  logic               rst_n_i,
    input  mmio_pkg::cpu_req_t req_i,
    input  logic               ram_sel_i,
    output mmio_pkg::wb_m2s_t  wb_o,
    input  mmio_pkg::wb_s2m_t  wb_i,
    output mmio_pkg::word_t    rdata_o,
    output logic               done_o
);

    import mmio_pkg::*;

    wb_state_e state_q;
    wb_state_e state_d;
    word_t     rdata_q;
    logic      start;
    logic      bus_open;

    // A RAM access is pending
    assign start = ram_sel_i && (req_i.read || req_i.write);

    assign bus_open = (state_q == WB_BUS);

    always_comb begin
        state_d = state_q;
        case (state_q)
            WB_IDLE: begin
                if (start) begin
                    state_d = WB_BUS;
                end
            end
            WB_BUS: begin
                if (wb_i.ack) begin
                    state_d = WB_DONE;
                end
            end
            // One-cycle gap keeps a held request from being issued twice
            WB_DONE: begin
                state_d = WB_IDLE;
            end
            default: begin
                state_d = WB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Capture the slave word on its ack
    always_ff @(posedge clk) begin
        if (bus_open && wb_i.ack) begin
            rdata_q <= wb_i.dat;
        end
    end

    // Address and data come straight from the held request
    always_comb begin
        wb_o.adr = req_i.addr;
        wb_o.dat = req_i.wdata;
        wb_o.sel = '1;
        wb_o.we  = req_i.write;
        wb_o.cyc = bus_open;
        wb_o.stb = bus_open;
    end

    assign rdata_o = rdata_q;
    assign done_o  = (state_q == WB_DONE);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_o.stb |-> wb_o.cyc);

endmodule

`default_nettype wire

//--- source/address_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module address_decoder (
    input  mmio_pkg::word_t   addr_i,
    input  logic              write_i,
    output mmio_pkg::region_e region_o,
    output logic              display_wen_o
);

    import mmio_pkg::*;

    logic hit_ram;
    logic hit_keypad;
    logic hit_display;

    // Window compares against the map
    assign hit_ram     = (addr_i >= RAM_BASE) && (addr_i <= RAM_LIMIT);
    assign hit_display = (addr_i >= DISPLAY_BASE) && (addr_i <= DISPLAY_LIMIT);
    assign hit_keypad  = (addr_i == KEYPAD_ADDR);

    always_comb begin
        if (hit_ram) begin
            region_o = REGION_RAM;
        end else if (hit_keypad) begin
            region_o = REGION_KEYPAD;
        end else if (hit_display) begin
            region_o = REGION_DISPLAY;
        end else begin
            region_o = REGION_NONE;
        end
    end

    // Display strobe only for stores into its window
    assign display_wen_o = write_i && hit_display;

    // Windows must never overlap, or the priority above would hide a target
    always_comb begin
        a_one_region: assert final ($onehot0({hit_ram, hit_keypad, hit_display}))
            else $error("address_decoder: address %h hits more than one region", addr_i);
    end

endmodule

`default_nettype wire

//--- source/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // Bus geometry
    localparam int WORD_WIDTH       = 32;
    localparam int SEL_WIDTH        = WORD_WIDTH / 8;
    localparam int BYTE_OFFSET_BITS = $clog2(SEL_WIDTH);

    // On-chip SRAM size in words
    localparam int SRAM_DEPTH     = 1024;
    localparam int SRAM_ADDR_BITS = $clog2(SRAM_DEPTH);

    // Byte address map
    localparam logic [WORD_WIDTH-1:0] RAM_BASE      = 32'h0000_0000;
    localparam logic [WORD_WIDTH-1:0] RAM_LIMIT     = 32'h0000_0FFF;
    localparam logic [WORD_WIDTH-1:0] DISPLAY_BASE  = 32'h0000_E000;
    localparam logic [WORD_WIDTH-1:0] DISPLAY_LIMIT = 32'h0000_E0FF;
    localparam logic [WORD_WIDTH-1:0] KEYPAD_ADDR   = 32'h0000_F000;

    // Load data for addresses outside the map
    localparam logic [WORD_WIDTH-1:0] ERROR_WORD = 32'hDEAD_BEEF;

    // Set while a key event waits to be read
    localparam int KEY_VALID_BIT = 31;

    typedef logic [WORD_WIDTH-1:0] word_t;

    typedef enum logic [1:0] {REGION_RAM, REGION_KEYPAD, REGION_DISPLAY, REGION_NONE} region_e;

    typedef enum logic [1:0] {WB_IDLE, WB_BUS, WB_DONE} wb_state_e;

    // CPU data port request
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } cpu_req_t;

    // Wishbone manager to slave
    typedef struct packed {
        word_t                adr;
        word_t                dat;
        logic [SEL_WIDTH-1:0] sel;
        logic                 we;
        logic                 stb;
        logic                 cyc;
    } wb_m2s_t;

    // Wishbone slave to manager
    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_s2m_t;

endpackage

`default_nettype wire
